//--- verilog/microCodePkg.sv
`default_nettype none

package microCodePkg;

        //--------------------------------------------------------------------
        // Bus and pin widths
        //--------------------------------------------------------------------

        localparam int busDataWidth = 32;
        localparam int pinWidth = 8;

        // Address bit splitting RAM from registers
        localparam int ramSelBit = 12;

        // Register word offsets
        localparam logic [3:0] regStartOffset = 4'h0;
        localparam logic [3:0] regEndOffset = 4'h4;
        localparam logic [3:0] regControlOffset = 4'h8;
        localparam logic [3:0] regStatusOffset = 4'hC;

        // Active HTRANS codes
        localparam logic [1:0] htransNonSeq = 2'd2;
        localparam logic [1:0] htransSeq = 2'd3;

        //--------------------------------------------------------------------
        // Microcode word
        //--------------------------------------------------------------------

        typedef enum logic [1:0] {
                opDrive = 2'd0,
                opDelay = 2'd1,
                opSample = 2'd2,
                opReserved = 2'd3
        } opCodeT;

        // One word, two views picked by the opcode
        typedef union packed {
                struct packed {
                        opCodeT opCode;
                        logic [20:0] spare;
                        logic outEn;
                        logic [7:0] pinData;
                } drive;
                struct packed {
                        opCodeT opCode;
                        logic [13:0] spare;
                        logic [15:0] count;
                } delay;
        } microCodeWordT;

endpackage

`default_nettype wire

//--- verilog/gpioPort.sv
`timescale 1ns/1ps
`default_nettype none

module gpioPort (
        input  wire                                clk,
        input  wire                                RSTn,
        input  wire                                driveLoad,
        input  wire  [microCodePkg::pinWidth-1:0]  driveData,
        input  wire                                driveEn,
        input  wire  [microCodePkg::pinWidth-1:0]  pinIn,
        output logic [microCodePkg::pinWidth-1:0]  pinOut,
        output logic                               pinOutEn,
        output logic [microCodePkg::pinWidth-1:0]  pinSync
);

        // First synchronizer stage
        logic [microCodePkg::pinWidth-1:0] pinMeta;

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        pinOut <= '0;
                        pinOutEn <= 1'b0;
                        pinMeta <= '0;
                        pinSync <= '0;
                end else begin
                        // Pins hold until the next drive
                        if (driveLoad) begin
                                pinOut <= driveData;
                                pinOutEn <= driveEn;
                        end
                        pinMeta <= pinIn;
                        pinSync <= pinMeta;
                end
        end

endmodule

`default_nettype wire

//--- verilog/ahbSlaveDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module ahbSlaveDecoder (
        input  wire                                  clk,
        input  wire                                  RSTn,
        input  wire                                  HSEL,
        input  wire  [31:0]                          HADDR,
        input  wire  [microCodePkg::busDataWidth-1:0] regRdata,
        output logic                                 regSel,
        output logic                                 ramSel,
        output logic [microCodePkg::busDataWidth-1:0] HRDATA
);

        // Data-phase flag for the read mux
        logic regPhase;

        //--------------------------------------------------------------------
        // Address phase decode
        //--------------------------------------------------------------------

        // Upper region is RAM
        assign ramSel = HSEL & HADDR[microCodePkg::ramSelBit];
        // Lower region is the register block
        assign regSel = HSEL & ~HADDR[microCodePkg::ramSelBit];

        //--------------------------------------------------------------------
        // Data phase read mux
        //--------------------------------------------------------------------

        // No wait states, so the data phase is always the next cycle
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        regPhase <= 1'b0;
                end else begin
                        regPhase <= regSel;
                end
        end

        // RAM is write-only from the bus and reads as all ones
        assign HRDATA = regPhase ? regRdata : '1;

endmodule

`default_nettype wire

//--- verilog/microCodeRegs.sv
`timescale 1ns/1ps
`default_nettype none

module microCodeRegs #(
        parameter int ramAddrWidth = 8
) (
        input  wire                                  clk,
        input  wire                                  RSTn,
        input  wire                                  regSel,
        input  wire  [31:0]                          HADDR,
        input  wire  [1:0]                           HTRANS,
        input  wire                                  HWRITE,
        input  wire  [microCodePkg::busDataWidth-1:0] HWDATA,
        input  wire                                  busy,
        input  wire  [ramAddrWidth-1:0]              fetchAddr,
        input  wire  [microCodePkg::pinWidth-1:0]    sampleData,
        output logic [microCodePkg::busDataWidth-1:0] regRdata,
        output logic [ramAddrWidth-1:0]              startAddr,
        output logic [ramAddrWidth-1:0]              endAddr,
        output logic                                 runPulse
);

        logic busActive;
        logic wrPhase;
        // Byte offset captured in the address phase
        logic [3:0] regAddr;

        assign busActive = (HTRANS == microCodePkg::htransNonSeq) ||
                           (HTRANS == microCodePkg::htransSeq);

        //--------------------------------------------------------------------
        // Address phase capture and data phase write
        //--------------------------------------------------------------------

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        wrPhase <= 1'b0;
                        regAddr <= '0;
                        startAddr <= '0;
                        endAddr <= '0;
                        runPulse <= 1'b0;
                end else begin
                        // Pulse lasts one cycle
                        runPulse <= 1'b0;
                        if (wrPhase) begin
                                case (regAddr)
                                        microCodePkg::regStartOffset:
                                                startAddr <= HWDATA[ramAddrWidth-1:0];
                                        microCodePkg::regEndOffset:
                                                endAddr <= HWDATA[ramAddrWidth-1:0];
                                        // Bit 0 requests a run
                                        microCodePkg::regControlOffset:
                                                runPulse <= HWDATA[0];
                                        default: ;
                                endcase
                        end
                        wrPhase <= regSel && busActive && HWRITE;
                        if (regSel && busActive) begin
                                regAddr <= HADDR[3:0];
                        end
                end
        end

        //--------------------------------------------------------------------
        // Read data
        //--------------------------------------------------------------------

        always_comb begin
                regRdata = '0;
                case (regAddr)
                        microCodePkg::regStartOffset:
                                regRdata[ramAddrWidth-1:0] = startAddr;
                        microCodePkg::regEndOffset:
                                regRdata[ramAddrWidth-1:0] = endAddr;
                        // Busy, current fetch address, last sample
                        microCodePkg::regStatusOffset: begin
                                regRdata[0] = busy;
                                regRdata[8 +: ramAddrWidth] = fetchAddr;
                                regRdata[16 +: microCodePkg::pinWidth] = sampleData;
                        end
                        // Control is a command, reads zero
                        default: ;
                endcase
        end

endmodule

`default_nettype wire

//--- verilog/microCodeRam.sv
`timescale 1ns/1ps
`default_nettype none

module microCodeRam #(
        parameter int ramAddrWidth = 8
) (
        input  wire                                  clk,
        input  wire                                  RSTn,
        input  wire                                  ramSel,
        input  wire  [31:0]                          HADDR,
        input  wire  [1:0]                           HTRANS,
        input  wire  [2:0]                           HSIZE,
        input  wire                                  HWRITE,
        input  wire  [microCodePkg::busDataWidth-1:0] HWDATA,
        input  wire  [ramAddrWidth-1:0]              fetchAddr,
        output microCodePkg::microCodeWordT          fetchWord
);

        localparam int laneCount = microCodePkg::busDataWidth / 8;

        logic [microCodePkg::busDataWidth-1:0] mem [2**ramAddrWidth];

        logic busActive;
        logic wrEn;
        logic [ramAddrWidth-1:0] wrAddr;
        logic [laneCount-1:0] wrStrb;
        logic [laneCount-1:0] laneMask;

        assign busActive = (HTRANS == microCodePkg::htransNonSeq) ||
                           (HTRANS == microCodePkg::htransSeq);

        // Little-endian lanes from size and low address bits
        always_comb begin
                case (HSIZE)
                        3'd0: laneMask = 4'b0001 << HADDR[1:0];
                        3'd1: laneMask = HADDR[1] ? 4'b1100 : 4'b0011;
                        default: laneMask = 4'b1111;
                endcase
        end

        //--------------------------------------------------------------------
        // Address phase capture
        //--------------------------------------------------------------------

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        wrEn <= 1'b0;
                        wrAddr <= '0;
                        wrStrb <= '0;
                end else begin
                        wrEn <= ramSel && busActive && HWRITE;
                        if (ramSel && busActive) begin
                                wrAddr <= HADDR[ramAddrWidth+1:2];
                                wrStrb <= laneMask;
                        end
                end
        end

        //--------------------------------------------------------------------
        // Storage
        //--------------------------------------------------------------------

        // Data phase lane writes, synchronous sequencer read
        always_ff @(posedge clk) begin
                for (int i = 0; i < laneCount; i++) begin
                        if (wrEn && wrStrb[i]) begin
                                mem[wrAddr][8*i +: 8] <= HWDATA[8*i +: 8];
                        end
                end
                fetchWord <= mem[fetchAddr];
        end

endmodule

`default_nettype wire

//--- verilog/microCodeSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module microCodeSequencer #(
        parameter int ramAddrWidth = 8
) (
        input  wire                                clk,
        input  wire                                RSTn,
        input  wire                                runPulse,
        input  wire  [ramAddrWidth-1:0]            startAddr,
        input  wire  [ramAddrWidth-1:0]            endAddr,
        input  wire  microCodePkg::microCodeWordT  fetchWord,
        input  wire  [microCodePkg::pinWidth-1:0]  pinSync,
        output logic [ramAddrWidth-1:0]            fetchAddr,
        output logic                               busy,
        output logic [microCodePkg::pinWidth-1:0]  sampleData,
        output logic                               driveLoad,
        output logic [microCodePkg::pinWidth-1:0]  driveData,
        output logic                               driveEn
);

        localparam logic [1:0] stIdle = 2'd0;
        localparam logic [1:0] stFetch = 2'd1;
        localparam logic [1:0] stExecute = 2'd2;
        localparam logic [1:0] stDelay = 2'd3;

        logic [1:0] state;
        logic [ramAddrWidth-1:0] pc;
        // End address frozen at run start
        logic [ramAddrWidth-1:0] endLatch;
        logic [15:0] delayCnt;
        logic lastWord;
        logic isDelay;

        assign fetchAddr = pc;
        assign busy = (state != stIdle);
        assign lastWord = (pc == endLatch);
        assign isDelay = (fetchWord.delay.opCode == microCodePkg::opDelay) &&
                         (fetchWord.delay.count != 16'd0);

        // Drive view straight to the GPIO registers
        assign driveLoad = (state == stExecute) &&
                           (fetchWord.drive.opCode == microCodePkg::opDrive);
        assign driveData = fetchWord.drive.pinData;
        assign driveEn = fetchWord.drive.outEn;

        //--------------------------------------------------------------------
        // FSM
        //--------------------------------------------------------------------

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        state <= stIdle;
                        pc <= '0;
                        endLatch <= '0;
                        delayCnt <= '0;
                        sampleData <= '0;
                end else begin
                        case (state)
                                // Runs only start from idle
                                stIdle: if (runPulse) begin
                                        pc <= startAddr;
                                        endLatch <= endAddr;
                                        state <= stFetch;
                                end
                                // RAM read in flight
                                stFetch: state <= stExecute;
                                stExecute: begin
                                        if (fetchWord.drive.opCode == microCodePkg::opSample)
                                                sampleData <= pinSync;
                                        if (isDelay) begin
                                                delayCnt <= fetchWord.delay.count;
                                                state <= stDelay;
                                        end else begin
                                                // Wraps modulo RAM depth
                                                pc <= lastWord ? pc : pc + 1'b1;
                                                state <= lastWord ? stIdle : stFetch;
                                        end
                                end
                                // One extra cycle per count
                                stDelay: begin
                                        delayCnt <= delayCnt - 1'b1;
                                        if (delayCnt == 16'd1) begin
                                                pc <= lastWord ? pc : pc + 1'b1;
                                                state <= lastWord ? stIdle : stFetch;
                                        end
                                end
                                default: state <= stIdle;
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- verilog/microCodeSoc.sv
`timescale 1ns/1ps
`default_nettype none

module microCodeSoc #(
        parameter int ramAddrWidth = 8
) (
        input  wire                                  clk,
        input  wire                                  RSTn,
        input  wire                                  HSEL,
        input  wire  [31:0]                          HADDR,
        input  wire  [1:0]                           HTRANS,
        input  wire  [2:0]                           HSIZE,
        input  wire                                  HWRITE,
        input  wire  [microCodePkg::busDataWidth-1:0] HWDATA,
        input  wire  [microCodePkg::pinWidth-1:0]    pinIn,
        output logic [microCodePkg::busDataWidth-1:0] HRDATA,
        output logic [microCodePkg::pinWidth-1:0]    pinOut,
        output logic                                 pinOutEn
);

        //--------------------------------------------------------------------
        // Bus side
        //--------------------------------------------------------------------

        logic regSel;
        logic ramSel;
        logic [microCodePkg::busDataWidth-1:0] regRdata;
        logic [ramAddrWidth-1:0] startAddr;
        logic [ramAddrWidth-1:0] endAddr;
        logic runPulse;

        //--------------------------------------------------------------------
        // Sequencer side
        //--------------------------------------------------------------------

        logic busy;
        logic [ramAddrWidth-1:0] fetchAddr;
        microCodePkg::microCodeWordT fetchWord;
        logic [microCodePkg::pinWidth-1:0] sampleData;
        logic driveLoad;
        logic [microCodePkg::pinWidth-1:0] driveData;
        logic driveEn;
        logic [microCodePkg::pinWidth-1:0] pinSync;

        // Register and RAM regions
        ahbSlaveDecoder ahbSlaveDecoder_i (
                .clk      (clk),
                .RSTn     (RSTn),
                .HSEL     (HSEL),
                .HADDR    (HADDR),
                .regRdata (regRdata),
                .regSel   (regSel),
                .ramSel   (ramSel),
                .HRDATA   (HRDATA)
        );

        microCodeRegs #(
                .ramAddrWidth (ramAddrWidth)
        ) microCodeRegs_i (
                .clk        (clk),
                .RSTn       (RSTn),
                .regSel     (regSel),
                .HADDR      (HADDR),
                .HTRANS     (HTRANS),
                .HWRITE     (HWRITE),
                .HWDATA     (HWDATA),
                .busy       (busy),
                .fetchAddr  (fetchAddr),
                .sampleData (sampleData),
                .regRdata   (regRdata),
                .startAddr  (startAddr),
                .endAddr    (endAddr),
                .runPulse   (runPulse)
        );

        microCodeRam #(
                .ramAddrWidth (ramAddrWidth)
        ) microCodeRam_i (
                .clk       (clk),
                .RSTn      (RSTn),
                .ramSel    (ramSel),
                .HADDR     (HADDR),
                .HTRANS    (HTRANS),
                .HSIZE     (HSIZE),
                .HWRITE    (HWRITE),
                .HWDATA    (HWDATA),
                .fetchAddr (fetchAddr),
                .fetchWord (fetchWord)
        );

        microCodeSequencer #(
                .ramAddrWidth (ramAddrWidth)
        ) microCodeSequencer_i (
                .clk        (clk),
                .RSTn       (RSTn),
                .runPulse   (runPulse),
                .startAddr  (startAddr),
                .endAddr    (endAddr),
                .fetchWord  (fetchWord),
                .pinSync    (pinSync),
                .fetchAddr  (fetchAddr),
                .busy       (busy),
                .sampleData (sampleData),
                .driveLoad  (driveLoad),
                .driveData  (driveData),
                .driveEn    (driveEn)
        );

        // Tristate is built outside, in the board wrapper
        gpioPort gpioPort_i (
                .clk       (clk),
                .RSTn      (RSTn),
                .driveLoad (driveLoad),
                .driveData (driveData),
                .driveEn   (driveEn),
                .pinIn     (pinIn),
                .pinOut    (pinOut),
                .pinOutEn  (pinOutEn),
                .pinSync   (pinSync)
        );

endmodule

`default_nettype wire

//--- tb/microCodeSocTb.sv
`timescale 1ns/1ps
`default_nettype none

module microCodeSocTb;

        localparam int rowCount = 4;
        localparam int maxWords = 4;
        localparam logic [31:0] ramBase = 32'h0000_1000;

        logic clk;
        logic RSTn;
        logic HSEL;
        logic [31:0] HADDR;
        logic [1:0] HTRANS;
        logic [2:0] HSIZE;
        logic HWRITE;
        logic [31:0] HWDATA;
        logic [7:0] pinIn;
        logic [31:0] HRDATA;
        logic [7:0] pinOut;
        logic pinOutEn;

        integer seed;
        int errors;
        int checks;
        logic [31:0] rd;
        int busyCycles;

        // Stimulus table with one row per program
        logic [31:0] prog [rowCount][maxWords];
        int progLen [rowCount];
        logic [7:0] loadAddr [rowCount];
        logic [7:0] startA [rowCount];
        logic [7:0] endA [rowCount];
        logic [7:0] pinVal [rowCount];
        logic [7:0] expOut [rowCount];
        logic expEn [rowCount];
        logic [7:0] expSample [rowCount];
        int minBusy [rowCount];

        microCodeSoc #(
                .ramAddrWidth (8)
        ) microCodeSoc_i (
                .clk      (clk),
                .RSTn     (RSTn),
                .HSEL     (HSEL),
                .HADDR    (HADDR),
                .HTRANS   (HTRANS),
                .HSIZE    (HSIZE),
                .HWRITE   (HWRITE),
                .HWDATA   (HWDATA),
                .pinIn    (pinIn),
                .HRDATA   (HRDATA),
                .pinOut   (pinOut),
                .pinOutEn (pinOutEn)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        //--------------------------------------------------------------------
        // Microcode word builders
        //--------------------------------------------------------------------

        // Opcode 31..30, enable bit 8, pin data 7..0
        function automatic logic [31:0] driveWord(input logic en, input logic [7:0] data);
                return {2'b00, 21'h0, en, data};
        endfunction

        function automatic logic [31:0] delayWord(input logic [15:0] count);
                return {2'b01, 14'h0, count};
        endfunction

        function automatic logic [31:0] sampleWord();
                return {2'b10, 30'h0};
        endfunction

        // Reserved opcode acts as a no-op
        function automatic logic [31:0] nopWord();
                return {2'b11, 30'h0};
        endfunction

        //--------------------------------------------------------------------
        // AHB master tasks enter and leave just after a falling edge
        //--------------------------------------------------------------------

        task automatic ahbWrite(input logic [31:0] addr, input logic [31:0] data,
                                input logic [2:0] size);
                HSEL = 1'b1;
                HADDR = addr;
                HTRANS = 2'd2;
                HSIZE = size;
                HWRITE = 1'b1;
                @(negedge clk);
                // Data phase with the bus idle behind it
                HSEL = 1'b0;
                HTRANS = 2'd0;
                HWRITE = 1'b0;
                HWDATA = data;
                @(negedge clk);
        endtask

        task automatic ahbRead(input logic [31:0] addr, output logic [31:0] data);
                HSEL = 1'b1;
                HADDR = addr;
                HTRANS = 2'd2;
                HSIZE = 3'd2;
                HWRITE = 1'b0;
                @(negedge clk);
                // Middle of the data phase
                data = HRDATA;
                HSEL = 1'b0;
                HTRANS = 2'd0;
        endtask

        task automatic checkValue(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
                checks++;
                if (got !== exp) begin
                        $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
                        errors++;
                end
        endtask

        // Polls status busy once per cycle
        task automatic waitIdle(output int cycles);
                logic [31:0] status;
                int polls;
                cycles = 0;
                polls = 0;
                ahbRead(32'hC, status);
                while (status[0] && polls < 500) begin
                        cycles += 1;
                        polls++;
                        ahbRead(32'hC, status);
                end
                if (status[0]) begin
                        $display("timeout: sequencer still busy after %0d status polls", polls);
                        errors++;
                end
        endtask

        task automatic runProgram(input logic [7:0] first, input logic [7:0] last,
                                  output int cycles);
                ahbWrite(32'h0, {24'h0, first}, 3'd2);
                ahbWrite(32'h4, {24'h0, last}, 3'd2);
                ahbWrite(32'h8, 32'h1, 3'd2);
                waitIdle(cycles);
        endtask

        //--------------------------------------------------------------------
        // Table rows
        //--------------------------------------------------------------------

        // Busy lasts two cycles per word plus each delay count
        task automatic fillTable();
                logic [31:0] rnd;
                logic [7:0] rndA;
                logic [7:0] rndB;
                rnd = $random(seed);
                rndA = rnd[7:0];
                rnd = $random(seed);
                rndB = rnd[7:0];
                // Two drives where the last one wins
                prog[0] = '{driveWord(1'b1, 8'hA5), driveWord(1'b1, 8'h3C), 32'h0, 32'h0};
                progLen[0] = 2;
                loadAddr[0] = 8'h08;
                startA[0] = 8'h08;
                endA[0] = 8'h09;
                pinVal[0] = 8'h00;
                expOut[0] = 8'h3C;
                expEn[0] = 1'b1;
                expSample[0] = 8'h00;
                minBusy[0] = 2 * 2;
                // Delay then sample of a random pin value
                prog[1] = '{driveWord(1'b1, 8'h5A), delayWord(16'd12), sampleWord(),
                            driveWord(1'b0, 8'h81)};
                progLen[1] = 4;
                loadAddr[1] = 8'h10;
                startA[1] = 8'h10;
                endA[1] = 8'h13;
                pinVal[1] = rndA;
                expOut[1] = 8'h81;
                expEn[1] = 1'b0;
                expSample[1] = rndA;
                minBusy[1] = 2 * 4 + 12;
                // Start above end runs through the wrap
                prog[2] = '{driveWord(1'b1, 8'h11), nopWord(), driveWord(1'b1, 8'hC3),
                            sampleWord()};
                progLen[2] = 4;
                loadAddr[2] = 8'hFE;
                startA[2] = 8'hFE;
                endA[2] = 8'h01;
                pinVal[2] = rndB;
                expOut[2] = 8'hC3;
                expEn[2] = 1'b1;
                expSample[2] = rndB;
                minBusy[2] = 2 * 4;
                // Without a sample the last value stays
                prog[3] = '{delayWord(16'd3), driveWord(1'b1, 8'h7E), 32'h0, 32'h0};
                progLen[3] = 2;
                loadAddr[3] = 8'h20;
                startA[3] = 8'h20;
                endA[3] = 8'h21;
                pinVal[3] = 8'h00;
                expOut[3] = 8'h7E;
                expEn[3] = 1'b1;
                expSample[3] = rndB;
                minBusy[3] = 2 * 2 + 3;
        endtask

        task automatic runRow(input int r);
                logic [7:0] wa;
                logic [31:0] status;
                int cycles;
                pinIn = pinVal[r];
                for (int i = 0; i < progLen[r]; i++) begin
                        // Word address wraps at the RAM depth
                        wa = loadAddr[r] + 8'(i);
                        ahbWrite(ramBase + {22'h0, wa, 2'b00}, prog[r][i], 3'd2);
                end
                runProgram(startA[r], endA[r], cycles);
                checkValue("pinOut", 32'(pinOut), 32'(expOut[r]));
                checkValue("pinOutEn", 32'(pinOutEn), 32'(expEn[r]));
                ahbRead(32'hC, status);
                checkValue("sampleData", 32'(status[23:16]), 32'(expSample[r]));
                checks++;
                if (cycles < minBusy[r]) begin
                        $display("busy too short in row %0d: %0d cycles, at least %0d needed",
                                 r, cycles, minBusy[r]);
                        errors++;
                end
        endtask

        //--------------------------------------------------------------------
        // Main sequence
        //--------------------------------------------------------------------

        initial begin
                RSTn = 1'b0;
                HSEL = 1'b0;
                HADDR = '0;
                HTRANS = 2'd0;
                HSIZE = 3'd2;
                HWRITE = 1'b0;
                HWDATA = '0;
                pinIn = '0;
                seed = 55100;
                errors = 0;
                checks = 0;
                repeat (4) @(negedge clk);
                RSTn = 1'b1;

                // Reset state
                checkValue("pinOut", 32'(pinOut), 32'h0);
                checkValue("pinOutEn", 32'(pinOutEn), 32'h0);
                ahbRead(32'hC, rd);
                checkValue("status.busy", 32'(rd[0]), 32'h0);
                checkValue("status.sample", 32'(rd[23:16]), 32'h0);

                // Register readback and an all-ones RAM region read
                ahbWrite(32'h0, 32'h12, 3'd2);
                ahbWrite(32'h4, 32'h34, 3'd2);
                ahbRead(32'h0, rd);
                checkValue("startAddr", rd, 32'h12);
                ahbRead(32'h4, rd);
                checkValue("endAddr", rd, 32'h34);
                ahbRead(ramBase, rd);
                checkValue("ramRead", rd, 32'hFFFF_FFFF);

                fillTable();
                for (int r = 0; r < rowCount; r++) begin
                        runRow(r);
                end

                // Only lane 0 is written and the other lanes carry junk
                ahbWrite(ramBase + 32'h24, 32'hDEAD_BE96, 3'd0);
                runProgram(8'h08, 8'h09, busyCycles);
                checkValue("pinOut", 32'(pinOut), 32'h96);
                checkValue("pinOutEn", 32'(pinOutEn), 32'h1);

                // Long run and a second run request while busy
                ahbWrite(ramBase + 32'hC0, driveWord(1'b1, 8'h42), 3'd2);
                ahbWrite(ramBase + 32'hC4, delayWord(16'd30), 3'd2);
                ahbWrite(ramBase + 32'hC8, driveWord(1'b1, 8'h24), 3'd2);
                ahbWrite(32'h0, 32'h30, 3'd2);
                ahbWrite(32'h4, 32'h32, 3'd2);
                ahbWrite(32'h8, 32'h1, 3'd2);
                ahbWrite(32'h0, 32'h08, 3'd2);
                ahbWrite(32'h4, 32'h09, 3'd2);
                ahbWrite(32'h8, 32'h1, 3'd2);
                waitIdle(busyCycles);
                checks++;
                if (busyCycles == 0) begin
                        $display("sequencer was not busy after the run command");
                        errors++;
                end
                checkValue("pinOut", 32'(pinOut), 32'h24);
                checkValue("pinOutEn", 32'(pinOutEn), 32'h1);
                // Must stay idle
                repeat (4) begin
                        ahbRead(32'hC, rd);
                        checkValue("status.busy", 32'(rd[0]), 32'h0);
                end
                checkValue("pinOut", 32'(pinOut), 32'h24);

                $display("checks %0d, errors %0d", checks, errors);
                if (errors == 0) begin
                        $display("TESTBENCH PASSED");
                end else begin
                        $display("TESTBENCH FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- compile.f
verilog/microCodePkg.sv
verilog/gpioPort.sv
verilog/ahbSlaveDecoder.sv
verilog/microCodeRegs.sv
verilog/microCodeRam.sv
verilog/microCodeSequencer.sv
verilog/microCodeSoc.sv
tb/microCodeSocTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps -f compile.f \
        --top-module microCodeSocTb -o microCodeSocTb
if [ $? -ne 0 ]; then
        echo "build failed"
        exit 1
fi

./obj_dir/microCodeSocTb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -q "TESTBENCH FAILED" "$log"; then
        exit 1
fi
exit 0
